//--- source/fir_pkg.sv
package fir_pkg;

    // datapath and register port widths
    localparam int data_w    = 32;
    localparam int addr_w    = 12;
    localparam int tap_num   = 11;
    localparam int tap_idx_w = 4;

    // register map
    localparam logic [addr_w-1:0] reg_ctrl_addr = 12'h000;
    localparam logic [addr_w-1:0] reg_len_addr  = 12'h010;
    // taps follow at word stride
    localparam logic [addr_w-1:0] reg_tap_base  = 12'h020;

    // control word bits
    typedef struct packed {
        logic rsvd;
        logic ap_idle;
        logic ap_done;
        logic ap_start;
    } ap_ctrl_t;

    // idle after reset
    localparam ap_ctrl_t ap_ctrl_rst = '{rsvd: 1'b0, ap_idle: 1'b1, ap_done: 1'b0,
                                         ap_start: 1'b0};

    typedef struct packed {
        logic [data_w-5:0] pad;
        ap_ctrl_t          ctrl;
    } ctrl_word_t;

    // one written data word seen as control bits or as a coefficient
    typedef union packed {
        ctrl_word_t               ctrl_word;
        logic signed [data_w-1:0] coef;
    } wr_word_u;

    // one tap memory access
    typedef struct packed {
        logic                 valid;
        logic                 write;
        logic [tap_idx_w-1:0] idx;
        logic [data_w-1:0]    wdata;
    } tap_req_t;

    // register block to engine
    typedef struct packed {
        logic              start;
        logic [data_w-1:0] len;
    } run_cfg_t;

    // engine to register block
    typedef struct packed {
        logic first_accept;
        logic finished;
    } run_stat_t;

endpackage

//--- source/fir_cfg_regs.sv
`timescale 1ns/10ps

module fir_cfg_regs
    import fir_pkg::*;
(
    input  logic              axis_clk,
    input  logic              axis_rst_n,
    input  logic              awvalid,
    input  logic [addr_w-1:0] awaddr,
    output logic              awready,
    input  logic              wvalid,
    input  logic [data_w-1:0] wdata,
    output logic              wready,
    input  logic              arvalid,
    input  logic [addr_w-1:0] araddr,
    output logic              arready,
    output logic              rvalid,
    output logic [data_w-1:0] rdata,
    input  logic              rready,
    output tap_req_t          cfg_req,
    input  logic              cfg_gnt,
    input  logic [data_w-1:0] cfg_rdata,
    output run_cfg_t          run_cfg,
    input  run_stat_t         run_stat
);

    ap_ctrl_t             ctrl;
    logic [data_w-1:0]    len;
    logic                 start_q;
    logic                 wr_ack;
    logic                 ar_rdy;
    logic                 rd_tap;
    logic                 rd_fill;
    logic [tap_idx_w-1:0] rd_idx;
    logic [addr_w-1:0]    aw_off;
    logic [addr_w-1:0]    ar_off;
    logic                 aw_is_tap;
    logic                 ar_is_tap;
    logic                 wr_pend;
    wr_word_u             wword;

    assign wword  = wdata;
    assign aw_off = awaddr - reg_tap_base;
    assign ar_off = araddr - reg_tap_base;

    // word aligned and inside the tap window
    assign aw_is_tap = (awaddr >= reg_tap_base) && (aw_off < addr_w'(4 * tap_num))
                       && (aw_off[1:0] == 2'b00);
    assign ar_is_tap = (araddr >= reg_tap_base) && (ar_off < addr_w'(4 * tap_num))
                       && (ar_off[1:0] == 2'b00);

    // writes only while idle and never under a pending tap read
    assign wr_pend = awvalid && wvalid && ctrl.ap_idle && !wr_ack && !rd_tap;

    assign awready     = wr_ack;
    assign wready      = wr_ack;
    assign arready     = ar_rdy;
    assign run_cfg.start = start_q;
    assign run_cfg.len   = len;

    // tap read first then tap write
    always_comb begin
        cfg_req = '0;
        if (rd_tap) begin
            cfg_req.valid = 1'b1;
            cfg_req.idx   = rd_idx;
        end else if (wr_pend && aw_is_tap) begin
            cfg_req.valid = 1'b1;
            cfg_req.write = 1'b1;
            cfg_req.idx   = aw_off[tap_idx_w+1:2];
            cfg_req.wdata = wword.coef;
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            ctrl    <= ap_ctrl_rst;
            len     <= '0;
            start_q <= 1'b0;
            wr_ack  <= 1'b0;
        end else begin
            start_q <= 1'b0;
            wr_ack  <= 1'b0;
            // tap writes wait for the grant
            if (wr_pend && (!aw_is_tap || cfg_gnt)) begin
                wr_ack <= 1'b1;
            end
            if (wr_ack) begin
                if ((awaddr == reg_ctrl_addr) && wword.ctrl_word.ctrl.ap_start) begin
                    ctrl.ap_start <= 1'b1;
                    ctrl.ap_idle  <= 1'b0;
                    ctrl.ap_done  <= 1'b0;
                    start_q       <= 1'b1;
                end
                if (awaddr == reg_len_addr) begin
                    len <= wdata;
                end
            end
            // done is read-to-clear
            if (arvalid && ar_rdy && (araddr == reg_ctrl_addr)) begin
                ctrl.ap_done <= 1'b0;
            end
            if (run_stat.first_accept) begin
                ctrl.ap_start <= 1'b0;
            end
            if (run_stat.finished) begin
                ctrl.ap_done <= 1'b1;
                ctrl.ap_idle <= 1'b1;
            end
        end
    end

    // read channel sequencing
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            ar_rdy  <= 1'b0;
            rd_tap  <= 1'b0;
            rd_fill <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            rd_fill <= 1'b0;
            if (arvalid && ar_rdy) begin
                ar_rdy <= 1'b0;
                if (ar_is_tap) begin
                    rd_tap <= 1'b1;
                end else begin
                    rvalid <= 1'b1;
                end
            end else if (!ar_rdy && !rd_tap && !rd_fill && !rvalid) begin
                ar_rdy <= 1'b1;
            end
            // memory data lands one cycle after the grant
            if (rd_tap && cfg_gnt) begin
                rd_tap  <= 1'b0;
                rd_fill <= 1'b1;
            end
            if (rd_fill) begin
                rvalid <= 1'b1;
            end
            if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (arvalid && ar_rdy) begin
            rd_idx <= ar_off[tap_idx_w+1:2];
            if (araddr == reg_ctrl_addr) begin
                rdata <= data_w'(ctrl);
            end else if (araddr == reg_len_addr) begin
                rdata <= len;
            end else begin
                rdata <= '0;
            end
        end else if (rd_fill) begin
            rdata <= cfg_rdata;
        end
    end

    // read data holds until the host takes it
    assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata));

    // a run only launches from idle
    assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        run_cfg.start |-> $past(ctrl.ap_idle));

endmodule

//--- source/fir_tap_arbiter.sv
`timescale 1ns/10ps

module fir_tap_arbiter
    import fir_pkg::*;
(
    input  logic              axis_clk,
    input  logic              axis_rst_n,
    input  tap_req_t          cfg_req,
    output logic              cfg_gnt,
    output logic [data_w-1:0] cfg_rdata,
    input  tap_req_t          eng_req,
    output logic [data_w-1:0] eng_rdata
);

    logic [data_w-1:0] taps [tap_num];
    logic [data_w-1:0] rd_q;
    // engine owned the previous cycle
    logic              eng_own;

    // engine has fixed priority
    assign cfg_gnt = cfg_req.valid && !eng_req.valid;

    always_ff @(posedge axis_clk) begin
        if (eng_req.valid) begin
            rd_q <= taps[eng_req.idx];
        end else if (cfg_gnt) begin
            if (cfg_req.write) begin
                taps[cfg_req.idx] <= cfg_req.wdata;
            end
            // old word on a write
            rd_q <= taps[cfg_req.idx];
        end
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            eng_own <= 1'b0;
        end else begin
            eng_own <= eng_req.valid;
        end
    end

    // read word to whoever owned the last cycle
    assign eng_rdata = eng_own ? rd_q : '0;
    assign cfg_rdata = eng_own ? '0 : rd_q;

    // engine port is read only
    assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        eng_req.valid |-> !eng_req.write);

endmodule

//--- source/fir_sample_ring.sv
`timescale 1ns/10ps

module fir_sample_ring
    import fir_pkg::*;
(
    input  logic                 axis_clk,
    input  logic                 axis_rst_n,
    input  logic                 clear,
    input  logic                 push,
    input  logic [data_w-1:0]    push_data,
    input  logic [tap_idx_w-1:0] rd_offset,
    output logic [data_w-1:0]    rd_data,
    output logic                 ring_busy
);

    logic [data_w-1:0]    slots [tap_num];
    logic [tap_idx_w-1:0] newest;
    logic [tap_idx_w-1:0] push_slot;
    logic [tap_idx_w-1:0] rd_slot;
    logic [tap_idx_w-1:0] clr_idx;
    logic                 clr_busy;

    assign ring_busy = clr_busy;

    // next slot after newest with wrap
    assign push_slot = (newest == tap_idx_w'(tap_num - 1)) ? '0 : newest + 1'b1;
    // offset back from newest modulo tap_num
    assign rd_slot = (rd_offset > newest) ? newest + tap_idx_w'(tap_num) - rd_offset
                                          : newest - rd_offset;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            clr_busy <= 1'b0;
            clr_idx  <= '0;
            newest   <= '0;
        end else if (clear) begin
            clr_busy <= 1'b1;
            clr_idx  <= '0;
            // first push lands in slot 0
            newest   <= tap_idx_w'(tap_num - 1);
        end else if (clr_busy) begin
            clr_idx <= clr_idx + 1'b1;
            if (clr_idx == tap_idx_w'(tap_num - 1)) begin
                clr_busy <= 1'b0;
            end
        end else if (push) begin
            newest <= push_slot;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (clr_busy) begin
            slots[clr_idx] <= '0;
        end else if (push) begin
            slots[push_slot] <= push_data;
        end
        rd_data <= slots[rd_slot];
    end

endmodule

//--- source/fir_mac_engine.sv
`timescale 1ns/10ps

module fir_mac_engine
    import fir_pkg::*;
(
    input  logic                 axis_clk,
    input  logic                 axis_rst_n,
    input  run_cfg_t             run_cfg,
    output run_stat_t            run_stat,
    input  logic                 ss_tvalid,
    input  logic [data_w-1:0]    ss_tdata,
    // accepted but not used, run end comes from the length register
    input  logic                 ss_tlast,
    output logic                 ss_tready,
    output logic                 sm_tvalid,
    output logic [data_w-1:0]    sm_tdata,
    output logic                 sm_tlast,
    input  logic                 sm_tready,
    output tap_req_t             eng_req,
    input  logic [data_w-1:0]    eng_rdata,
    output logic                 ring_clear,
    output logic                 ring_push,
    output logic [data_w-1:0]    ring_push_data,
    output logic [tap_idx_w-1:0] ring_rd_offset,
    input  logic [data_w-1:0]    ring_rd_data,
    input  logic                 ring_busy
);

    typedef enum logic [2:0] {
        st_idle,
        st_clear,
        st_wait,
        st_mac,
        st_out
    } eng_st_t;

    eng_st_t              st;
    logic [tap_idx_w-1:0] tap_cnt;
    logic [data_w-1:0]    run_cnt;
    logic [data_w-1:0]    prod;
    logic [data_w-1:0]    acc;
    logic                 accept;
    logic                 out_take;

    assign accept   = ss_tvalid && ss_tready;
    assign out_take = sm_tvalid && sm_tready;

    // history cleared as the run starts
    assign ring_clear     = (st == st_idle) && run_cfg.start;
    assign ring_push      = accept;
    assign ring_push_data = ss_tdata;

    // tap k pairs with the sample k back
    assign eng_req.valid  = (st == st_mac) && (tap_cnt < tap_idx_w'(tap_num));
    assign eng_req.write  = 1'b0;
    assign eng_req.idx    = tap_cnt;
    assign eng_req.wdata  = '0;
    assign ring_rd_offset = eng_req.valid ? tap_cnt : '0;

    assign run_stat.first_accept = accept && (run_cnt == '0);
    assign run_stat.finished     = out_take && sm_tlast;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            st        <= st_idle;
            tap_cnt   <= '0;
            run_cnt   <= '0;
            ss_tready <= 1'b0;
            sm_tvalid <= 1'b0;
            sm_tlast  <= 1'b0;
        end else begin
            case (st)
                st_idle: begin
                    if (run_cfg.start) begin
                        st      <= st_clear;
                        run_cnt <= '0;
                    end
                end
                // ring goes busy the cycle after the clear pulse
                st_clear: begin
                    if (!ring_busy) begin
                        st        <= st_wait;
                        ss_tready <= 1'b1;
                    end
                end
                st_wait: begin
                    if (accept) begin
                        st        <= st_mac;
                        ss_tready <= 1'b0;
                        tap_cnt   <= '0;
                    end
                end
                // reads at 0..10 then data then product then result
                st_mac: begin
                    tap_cnt <= tap_cnt + 1'b1;
                    if (tap_cnt == tap_idx_w'(tap_num + 1)) begin
                        st        <= st_out;
                        sm_tvalid <= 1'b1;
                        sm_tlast  <= (run_cnt == run_cfg.len - 1'b1);
                        run_cnt   <= run_cnt + 1'b1;
                    end
                end
                // hold the result until taken
                st_out: begin
                    if (out_take) begin
                        sm_tvalid <= 1'b0;
                        sm_tlast  <= 1'b0;
                        if (sm_tlast) begin
                            st <= st_idle;
                        end else begin
                            st        <= st_wait;
                            ss_tready <= 1'b1;
                        end
                    end
                end
                default: begin
                    st <= st_idle;
                end
            endcase
        end
    end

    // wrapping 32-bit multiply-accumulate
    always_ff @(posedge axis_clk) begin
        prod <= eng_rdata * ring_rd_data;
        if (accept) begin
            acc <= '0;
        end else if ((st == st_mac) && (tap_cnt >= tap_idx_w'(2))
                     && (tap_cnt <= tap_idx_w'(tap_num))) begin
            acc <= acc + prod;
        end
        // last product folds straight into the output
        if ((st == st_mac) && (tap_cnt == tap_idx_w'(tap_num + 1))) begin
            sm_tdata <= acc + prod;
        end
    end

    // result stable under back-pressure
    assert property (@(posedge axis_clk) disable iff (!axis_rst_n)
        sm_tvalid && !sm_tready |=> sm_tvalid && $stable(sm_tdata));

endmodule

//--- source/fir_top.sv
`timescale 1ns/10ps

module fir_top
    import fir_pkg::*;
(
    input  logic              axis_clk,
    input  logic              axis_rst_n,
    input  logic              awvalid,
    input  logic [addr_w-1:0] awaddr,
    output logic              awready,
    input  logic              wvalid,
    input  logic [data_w-1:0] wdata,
    output logic              wready,
    input  logic              arvalid,
    input  logic [addr_w-1:0] araddr,
    output logic              arready,
    output logic              rvalid,
    output logic [data_w-1:0] rdata,
    input  logic              rready,
    input  logic              ss_tvalid,
    input  logic [data_w-1:0] ss_tdata,
    input  logic              ss_tlast,
    output logic              ss_tready,
    output logic              sm_tvalid,
    output logic [data_w-1:0] sm_tdata,
    output logic              sm_tlast,
    input  logic              sm_tready
);

    tap_req_t             cfg_req;
    tap_req_t             eng_req;
    logic                 cfg_gnt;
    logic [data_w-1:0]    cfg_rdata;
    logic [data_w-1:0]    eng_rdata;
    run_cfg_t             run_cfg;
    run_stat_t            run_stat;
    logic                 ring_clear;
    logic                 ring_push;
    logic [data_w-1:0]    ring_push_data;
    logic [tap_idx_w-1:0] ring_rd_offset;
    logic [data_w-1:0]    ring_rd_data;
    logic                 ring_busy;

    // register port and control state
    fir_cfg_regs u_cfg_regs (
        .axis_clk, .axis_rst_n,
        .awvalid, .awaddr, .awready, .wvalid, .wdata, .wready,
        .arvalid, .araddr, .arready, .rvalid, .rdata, .rready,
        .cfg_req, .cfg_gnt, .cfg_rdata, .run_cfg, .run_stat
    );

    // coefficient memory shared by both peers
    fir_tap_arbiter u_tap_arbiter (
        .axis_clk, .axis_rst_n,
        .cfg_req, .cfg_gnt, .cfg_rdata, .eng_req, .eng_rdata
    );

    fir_sample_ring u_sample_ring (
        .axis_clk, .axis_rst_n,
        .clear     (ring_clear),
        .push      (ring_push),
        .push_data (ring_push_data),
        .rd_offset (ring_rd_offset),
        .rd_data   (ring_rd_data),
        .ring_busy (ring_busy)
    );

    fir_mac_engine u_mac_engine (
        .axis_clk, .axis_rst_n,
        .run_cfg, .run_stat,
        .ss_tvalid, .ss_tdata, .ss_tlast, .ss_tready,
        .sm_tvalid, .sm_tdata, .sm_tlast, .sm_tready,
        .eng_req, .eng_rdata,
        .ring_clear, .ring_push, .ring_push_data, .ring_rd_offset,
        .ring_rd_data, .ring_busy
    );

endmodule

//--- verification/fir_tb.sv
`timescale 1ns/10ps

module fir_tb
    import fir_pkg::*;
();

    // test kinds in the table
    localparam int k_write  = 0;
    localparam int k_read   = 1;
    localparam int k_run    = 2;
    localparam int k_run_bp = 3;
    localparam int run_len  = 14;
    // per-sample budget beyond the pipeline depth
    localparam int bp_margin = 8;

    logic              axis_clk;
    logic              axis_rst_n;
    logic              awvalid;
    logic [addr_w-1:0] awaddr;
    logic              awready;
    logic              wvalid;
    logic [data_w-1:0] wdata;
    logic              wready;
    logic              arvalid;
    logic [addr_w-1:0] araddr;
    logic              arready;
    logic              rvalid;
    logic [data_w-1:0] rdata;
    logic              rready;
    logic              ss_tvalid;
    logic [data_w-1:0] ss_tdata;
    logic              ss_tlast;
    logic              ss_tready;
    logic              sm_tvalid;
    logic [data_w-1:0] sm_tdata;
    logic              sm_tlast;
    logic              sm_tready;

    logic [data_w-1:0] coef [tap_num];
    logic [data_w-1:0] samples [run_len];
    logic [31:0]       lfsr_q;
    int                cycle_cnt;
    int                cycle_limit;

    // stimulus table
    string             t_name[$];
    int                t_kind[$];
    logic [31:0]       t_arg[$];
    logic [31:0]       t_val[$];

    fir_top dut0 (.*);

    always #50 axis_clk = ~axis_clk;

    // advance to 1 ns past the next rising edge
    task automatic next_cycle();
        @(posedge axis_clk);
        #1;
    endtask

    // fibonacci, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // direct form convolution, history zero before the run
    function automatic logic [data_w-1:0] fir_model(input int n);
        logic [data_w-1:0] sum;
        sum = '0;
        for (int k = 0; k < tap_num; k++) begin
            if (n - k >= 0) begin
                sum = sum + coef[k] * samples[n - k];
            end
        end
        return sum;
    endfunction

    task automatic add_test(input string name, input int kind, input logic [31:0] arg,
                            input logic [31:0] val);
        t_name.push_back(name);
        t_kind.push_back(kind);
        t_arg.push_back(arg);
        t_val.push_back(val);
    endtask

    // address and data offered together until both readies
    task automatic reg_write(input logic [addr_w-1:0] addr, input logic [data_w-1:0] data);
        logic done;
        awvalid = 1'b1;
        awaddr  = addr;
        wvalid  = 1'b1;
        wdata   = data;
        done    = 1'b0;
        while (!done) begin
            @(negedge axis_clk);
            done = awready && wready;
            next_cycle();
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
    endtask

    task automatic reg_read(input logic [addr_w-1:0] addr, output logic [data_w-1:0] data);
        logic done;
        arvalid = 1'b1;
        araddr  = addr;
        done    = 1'b0;
        while (!done) begin
            @(negedge axis_clk);
            done = arready;
            next_cycle();
        end
        arvalid = 1'b0;
        rready  = 1'b1;
        done    = 1'b0;
        // tap reads take longer, wait on rvalid
        while (!done) begin
            @(negedge axis_clk);
            done = rvalid;
            data = rdata;
            next_cycle();
        end
        rready = 1'b0;
    endtask

    // one full run, one sample in flight at a time
    task automatic stream_run(input string name, input int len, input logic bp,
                              input logic [data_w-1:0] ctrl_exp, output int errs);
        logic [data_w-1:0] got;
        logic              got_last;
        logic              done;
        logic [data_w-1:0] ctrl_now;
        logic [data_w-1:0] exp_val;
        errs = 0;
        reg_write(reg_ctrl_addr, 32'h1);
        for (int i = 0; i < len; i++) begin
            ss_tvalid = 1'b1;
            ss_tdata  = samples[i];
            ss_tlast  = (i == len - 1);
            done      = 1'b0;
            while (!done) begin
                @(negedge axis_clk);
                done = ss_tready;
                next_cycle();
            end
            ss_tvalid = 1'b0;
            ss_tlast  = 1'b0;
            // control word while the first sample computes
            if (i == 0) begin
                reg_read(reg_ctrl_addr, ctrl_now);
                if (ctrl_now !== ctrl_exp) begin
                    $display("MISMATCH %s ctrl: expected %h, actual %h", name, ctrl_exp,
                             ctrl_now);
                    errs++;
                end
            end
            done = 1'b0;
            while (!done) begin
                if (bp) begin
                    lfsr_q    = lfsr_next(lfsr_q);
                    sm_tready = lfsr_q[0];
                end else begin
                    sm_tready = 1'b1;
                end
                @(negedge axis_clk);
                done     = sm_tvalid && sm_tready;
                got      = sm_tdata;
                got_last = sm_tlast;
                next_cycle();
            end
            sm_tready = 1'b0;
            exp_val   = fir_model(i);
            if (got !== exp_val) begin
                $display("MISMATCH %s out %0d: expected %h, actual %h", name, i, exp_val, got);
                errs++;
            end
            if (got_last !== (i == len - 1)) begin
                $display("MISMATCH %s last %0d: expected %b, actual %b", name, i,
                         (i == len - 1), got_last);
                errs++;
            end
        end
    endtask

    // hard stop once the budget is spent
    initial begin
        cycle_cnt = 0;
        wait (cycle_limit > 0);
        while (cycle_cnt < cycle_limit) begin
            @(posedge axis_clk);
            cycle_cnt++;
        end
        $display("timeout: run did not finish within %0d cycles", cycle_limit);
        $display("Checks failed");
        $finish;
    end

    initial begin
        int               errs;
        int               fail_tests;
        int               err_total;
        logic [data_w-1:0] rd;
        axis_clk    = 1'b0;
        axis_rst_n  = 1'b0;
        awvalid     = 1'b0;
        awaddr      = '0;
        wvalid      = 1'b0;
        wdata       = '0;
        arvalid     = 1'b0;
        araddr      = '0;
        rready      = 1'b0;
        ss_tvalid   = 1'b0;
        ss_tdata    = '0;
        ss_tlast    = 1'b0;
        sm_tready   = 1'b0;
        lfsr_q      = 32'h2f3;
        cycle_limit = 0;
        fail_tests  = 0;
        err_total   = 0;
        // mixed signs, last tap large enough to wrap
        coef = '{32'd3, 32'hffff_fffe, 32'd5, 32'd7, 32'hffff_ffff, 32'd11,
                 32'd17, 32'd13, 32'hffff_fff7, 32'd2, 32'h0001_0000};
        samples = '{32'd1, 32'd2, 32'd3, 32'hffff_fffc, 32'd5, 32'd6, 32'd7,
                    32'd8, 32'h7fff_fff0, 32'd10, 32'hffff_fff5, 32'd12,
                    32'h8000_0001, 32'd14};

        add_test("ctrl_after_reset", k_read, reg_ctrl_addr, 32'h4);
        for (int k = 0; k < tap_num; k++) begin
            add_test($sformatf("tap%0d_write", k), k_write, reg_tap_base + 4 * k, coef[k]);
        end
        add_test("len_write", k_write, reg_len_addr, run_len);
        for (int k = 0; k < tap_num; k++) begin
            add_test($sformatf("tap%0d_read", k), k_read, reg_tap_base + 4 * k, coef[k]);
        end
        add_test("len_read", k_read, reg_len_addr, run_len);
        add_test("unmapped_read", k_read, 32'h100, 32'h0);
        add_test("run_ready", k_run, run_len, 32'h0);
        add_test("ctrl_done", k_read, reg_ctrl_addr, 32'h6);
        add_test("ctrl_done_cleared", k_read, reg_ctrl_addr, 32'h4);
        add_test("run_backpressure", k_run_bp, run_len, 32'h0);
        // starts straight away, history must be zero again
        add_test("run_again", k_run, run_len, 32'h0);
        add_test("ctrl_done_again", k_read, reg_ctrl_addr, 32'h6);
        add_test("ctrl_idle_again", k_read, reg_ctrl_addr, 32'h4);

        cycle_limit = 200;
        for (int t = 0; t < t_name.size(); t++) begin
            if (t_kind[t] == k_run || t_kind[t] == k_run_bp) begin
                cycle_limit += t_arg[t] * (tap_num + 3 + bp_margin);
            end
        end

        repeat (3) @(posedge axis_clk);
        #1;
        axis_rst_n = 1'b1;

        for (int t = 0; t < t_name.size(); t++) begin
            errs = 0;
            case (t_kind[t])
                k_write: begin
                    reg_write(t_arg[t][addr_w-1:0], t_val[t]);
                end
                k_read: begin
                    reg_read(t_arg[t][addr_w-1:0], rd);
                    if (rd !== t_val[t]) begin
                        $display("MISMATCH %s: expected %h, actual %h", t_name[t], t_val[t], rd);
                        errs++;
                    end
                end
                k_run: begin
                    stream_run(t_name[t], t_arg[t], 1'b0, t_val[t], errs);
                end
                default: begin
                    stream_run(t_name[t], t_arg[t], 1'b1, t_val[t], errs);
                end
            endcase
            if (errs == 0) begin
                $display("test %s: ok", t_name[t]);
            end else begin
                $display("test %s: %0d errors", t_name[t], errs);
                fail_tests++;
                err_total += errs;
            end
        end

        $display("tests %0d, failed %0d, errors %0d", t_name.size(), fail_tests, err_total);
        if (fail_tests == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- verilog.f
source/fir_pkg.sv
source/fir_cfg_regs.sv
source/fir_tap_arbiter.sv
source/fir_sample_ring.sv
source/fir_mac_engine.sv
source/fir_top.sv
verification/fir_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the FIR testbench with Verilator, run it, then judge the log
set -o pipefail
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module fir_tb \
    -f verilog.f -o fir_sim > build.log 2>&1 \
    && ./obj_dir/fir_sim 2>&1 | tee sim.log \
    || { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "Checks failed" sim.log && { echo "simulation FAILED"; exit 1; }
echo "simulation passed"
exit 0
